// File: build.f
hdl/ctrl_pkg.sv
hdl/inst_buffer.sv
hdl/decode.sv
hdl/rename.sv
hdl/rob.sv
hdl/ctrl_block.sv
testbench/tb_clkgen.sv
testbench/tb_ctrl_block.sv

// File: Makefile
TOP := tb_ctrl_block

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: testbench/tb_ctrl_block.sv
`timescale 1ns/100ps

module tb_ctrl_block import ctrl_pkg::*; ();

    localparam int IMG_WORDS = 64;
    localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        logic [31:0] pc;
        op_class_e   op;
        areg_t       rd;
        logic        has_dest;
        preg_t       pdst;
        rob_idx_t    idx;
        logic        mispred;
        logic [31:0] target;
    } inflight_t;

    logic         clk;
    logic         i_rst         = 1'b1;
    logic         i_fetch_valid = 1'b0;
    fetch_entry_t i_fetch_data  = '0;
    logic         i_issue_ready = 1'b0;
    logic         i_wb_valid    = 1'b0;
    wb_info_t     i_wb_info     = '0;
    logic         o_fetch_ready;
    logic         o_issue_valid;
    issue_info_t  o_issue_info;
    logic         o_commit_valid;
    commit_info_t o_commit_info;
    logic         o_squash_valid;
    squash_info_t o_squash_info;

    // program image with branch outcomes kept beside the words
    logic [31:0] image   [IMG_WORDS];
    op_class_e   op_img  [IMG_WORDS];
    logic        mis_img [IMG_WORDS];
    logic [31:0] tgt_img [IMG_WORDS];
    logic        image_ready = 1'b0;
    logic [31:0] rng         = 32'ha4f5;

    // reference model
    preg_t       spec_map   [ARCH_REGS];
    preg_t       commit_map [ARCH_REGS];
    preg_t       fl         [FL_DEPTH];
    logic [5:0]  fl_spec_head;
    logic [5:0]  fl_commit_head;
    logic [5:0]  fl_tail;
    rob_idx_t    alloc_idx;
    logic [31:0] arch_pc;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_q [$];
    inflight_t   rob_q   [$];
    rob_idx_t    pending [$];
    logic        wb_mis  [2**ROB_IDX_W];
    logic [31:0] wb_tgt  [2**ROB_IDX_W];

    int   retired     = 0;
    int   issued      = 0;
    int   squashes    = 0;
    int   errors      = 0;
    int   flow_errors = 0;
    logic hold_ready  = 1'b0;
    logic fetch_en    = 1'b1;

    tb_clkgen #(.PERIOD(40)) u_clkgen (.o_clk(clk));

    ctrl_block #(.IBUF_DEPTH(4), .ROB_DEPTH(16)) dut0 (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_fetch_valid  (i_fetch_valid),
        .o_fetch_ready  (o_fetch_ready),
        .i_fetch_data   (i_fetch_data),
        .o_issue_valid  (o_issue_valid),
        .i_issue_ready  (i_issue_ready),
        .o_issue_info   (o_issue_info),
        .i_wb_valid     (i_wb_valid),
        .i_wb_info      (i_wb_info),
        .o_commit_valid (o_commit_valid),
        .o_commit_info  (o_commit_info),
        .o_squash_valid (o_squash_valid),
        .o_squash_info  (o_squash_info)
    );

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1103515245 + 32'd12345;
        return {16'd0, rng[31:16]};
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // weighted op mix with roughly 3% illegal words
    task automatic build_image();
        logic [31:0] sel;
        logic [31:0] bits;
        logic [6:0]  opc;
        for (int i = 0; i < IMG_WORDS; i++) begin
            sel        = next_rand() % 100;
            bits       = (next_rand() << 16) | next_rand();
            mis_img[i] = 1'b0;
            tgt_img[i] = '0;
            if (sel < 3) begin
                opc       = 7'h0b;
                op_img[i] = OP_ILLEGAL;
            end else if (sel < 48) begin
                opc       = bits[25] ? 7'h33 : 7'h13;
                op_img[i] = OP_ALU;
            end else if (sel < 68) begin
                opc       = 7'h03;
                op_img[i] = OP_LOAD;
            end else if (sel < 82) begin
                opc       = 7'h23;
                op_img[i] = OP_STORE;
            end else begin
                opc        = 7'h63;
                op_img[i]  = OP_BRANCH;
                mis_img[i] = ((next_rand() % 4) == 0);
                tgt_img[i] = (next_rand() % IMG_WORDS) << 2;
            end
            image[i] = {bits[31:7], opc};
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i]   = preg_t'(i);
            commit_map[i] = preg_t'(i);
        end
        for (int i = 0; i < FL_DEPTH; i++) begin
            fl[i] = preg_t'(ARCH_REGS + i);
        end
        fl_spec_head   = '0;
        fl_commit_head = '0;
        fl_tail        = 6'd32;
        alloc_idx      = '0;
        arch_pc        = '0;
        fetch_pc       = '0;
        fetch_q.delete();
        rob_q.delete();
        pending.delete();
    endtask

    // commit or squash of the oldest instruction in program order
    task automatic check_retire();
        inflight_t     r;
        logic          exp_squash;
        squash_cause_e exp_cause;
        if (o_commit_valid || o_squash_valid) begin
            retired++;
            if (rob_q.size() == 0) begin
                report_mismatch("retire seen with no instruction outstanding");
            end else begin
                r          = rob_q.pop_front();
                exp_squash = (r.op == OP_ILLEGAL) || r.mispred;
                exp_cause  = (r.op == OP_ILLEGAL) ? SQ_EXCEPT : SQ_MISPRED;
                if (r.pc != arch_pc) begin
                    report_mismatch($sformatf("retired pc %0h, path expects %0h", r.pc, arch_pc));
                end
                if (o_commit_valid != (r.op != OP_ILLEGAL)) begin
                    report_mismatch($sformatf("commit_valid %0b for pc %0h", o_commit_valid, r.pc));
                end
                if (o_squash_valid != exp_squash) begin
                    report_mismatch($sformatf("squash_valid %0b for pc %0h", o_squash_valid, r.pc));
                end
                if (o_commit_valid) begin
                    if (o_commit_info.rob_idx != r.idx || o_commit_info.pc != r.pc
                            || o_commit_info.rd != r.rd
                            || o_commit_info.has_dest != r.has_dest) begin
                        report_mismatch($sformatf(
                            "commit idx %0d pc %0h rd %0d dest %0b, expected %0d %0h %0d %0b",
                            o_commit_info.rob_idx, o_commit_info.pc, o_commit_info.rd,
                            o_commit_info.has_dest, r.idx, r.pc, r.rd, r.has_dest));
                    end
                    if (r.has_dest) begin
                        if (o_commit_info.pdst != r.pdst
                                || o_commit_info.old_pdst != commit_map[r.rd]) begin
                            report_mismatch($sformatf("commit pdst %0d old %0d, expected %0d %0d",
                                o_commit_info.pdst, o_commit_info.old_pdst,
                                r.pdst, commit_map[r.rd]));
                        end
                        fl[fl_tail[4:0]] = commit_map[r.rd];
                        fl_tail          = fl_tail + 1'b1;
                        commit_map[r.rd] = r.pdst;
                        fl_commit_head   = fl_commit_head + 1'b1;
                    end
                end
                arch_pc = r.mispred ? r.target : r.pc + 32'd4;
                if (exp_squash && o_squash_valid
                        && (o_squash_info.cause != exp_cause || o_squash_info.pc != arch_pc)) begin
                    report_mismatch($sformatf("squash cause %0d pc %0h, expected %0d %0h",
                        o_squash_info.cause, o_squash_info.pc, exp_cause, arch_pc));
                end
            end
        end
        // flush restores the committed view
        if (o_squash_valid) begin
            squashes++;
            rob_q.delete();
            fetch_q.delete();
            pending.delete();
            spec_map     = commit_map;
            fl_spec_head = fl_commit_head;
            alloc_idx    = '0;
        end
    endtask

    task automatic check_issue();
        inflight_t   r;
        logic [31:0] inst;
        if (o_issue_valid && i_issue_ready) begin
            issued++;
            if (fetch_q.size() == 0) begin
                report_error("an instruction issued that was never fetched");
            end else begin
                r.pc       = fetch_q.pop_front();
                inst       = image[r.pc[7:2]];
                r.op       = op_img[r.pc[7:2]];
                r.rd       = inst[11:7];
                r.has_dest = ((r.op == OP_ALU) || (r.op == OP_LOAD)) && (r.rd != 5'd0);
                r.mispred  = mis_img[r.pc[7:2]];
                r.target   = tgt_img[r.pc[7:2]];
                r.idx      = alloc_idx;
                r.pdst     = '0;
                if (r.has_dest) begin
                    if (fl_spec_head == fl_tail) begin
                        report_error("rename took a register from an empty free list");
                    end
                    r.pdst       = fl[fl_spec_head[4:0]];
                    fl_spec_head = fl_spec_head + 1'b1;
                end
                if (o_issue_info.rob_idx != alloc_idx || o_issue_info.op != r.op) begin
                    report_mismatch($sformatf("issue idx %0d op %0d, expected %0d %0d",
                        o_issue_info.rob_idx, o_issue_info.op, alloc_idx, r.op));
                end
                if (o_issue_info.psrc1 != spec_map[inst[19:15]]
                        || o_issue_info.psrc2 != spec_map[inst[24:20]]
                        || o_issue_info.pdst != r.pdst) begin
                    report_mismatch($sformatf("pc %0h tags %0d %0d %0d, expected %0d %0d %0d",
                        r.pc, o_issue_info.psrc1, o_issue_info.psrc2, o_issue_info.pdst,
                        spec_map[inst[19:15]], spec_map[inst[24:20]], r.pdst));
                end
                if (r.has_dest) begin
                    spec_map[r.rd] = r.pdst;
                end
                // illegal entries are complete at allocation
                if (r.op != OP_ILLEGAL) begin
                    pending.push_back(alloc_idx);
                    wb_mis[alloc_idx] = r.mispred;
                    wb_tgt[alloc_idx] = r.target;
                end
                alloc_idx = alloc_idx + 1'b1;
                rob_q.push_back(r);
            end
        end
    endtask

    always @(posedge clk) begin : cycle
        int       k;
        rob_idx_t idx;
        if (i_rst) begin
            if (!image_ready) begin
                build_image();
                image_ready = 1'b1;
            end
            reset_model();
            i_fetch_valid <= 1'b0;
            i_issue_ready <= 1'b0;
            i_wb_valid    <= 1'b0;
        end else begin
            check_retire();
            check_issue();
            if (o_squash_valid) begin
                fetch_pc = arch_pc;
            end else if (i_fetch_valid && o_fetch_ready) begin
                fetch_q.push_back(fetch_pc);
                fetch_pc = fetch_pc + 32'd4;
            end
            i_fetch_valid <= fetch_en && ((next_rand() % 8) != 0);
            i_fetch_data  <= '{pc: fetch_pc, inst: image[fetch_pc[7:2]]};
            i_issue_ready <= !hold_ready && ((next_rand() % 4) != 0);
            // random execution unit with at most one writeback per cycle
            if (o_squash_valid || pending.size() == 0 || (next_rand() % 3) == 0) begin
                i_wb_valid <= 1'b0;
            end else begin
                k   = int'(next_rand() % $unsigned(pending.size()));
                idx = pending[k];
                pending.delete(k);
                i_wb_valid <= 1'b1;
                i_wb_info  <= '{rob_idx: idx, mispred: wb_mis[idx], target: wb_tgt[idx]};
            end
        end
    end

    initial begin : control
        int          n;
        int          goal;
        logic        offer_held;
        issue_info_t offer;
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;

        n = 0;
        while (retired < 300 && n < 20000) begin
            @(negedge clk);
            n++;
        end
        if (retired < 300) begin
            flow_errors++;
            $display("Error: timed out before 300 instructions retired");
        end

        // with the execution unit not accepting, the front end must fill up and stall
        if (flow_errors == 0) begin
            hold_ready = 1'b1;
            @(negedge clk);
            offer_held = o_issue_valid && !o_squash_valid;
            offer      = o_issue_info;
            n          = 0;
            while ((o_fetch_ready || o_squash_valid) && n < 400) begin
                @(negedge clk);
                n++;
                // an offered instruction waits unchanged unless squashed
                if (offer_held && !o_squash_valid
                        && (!o_issue_valid || o_issue_info != offer)) begin
                    flow_errors++;
                    $display("Error: issue offer changed while issue was held off");
                end
                offer_held = o_issue_valid && !o_squash_valid;
                offer      = o_issue_info;
            end
            if (o_fetch_ready || o_squash_valid) begin
                flow_errors++;
                $display("Error: fetch never stalled while issue was held off");
            end
            hold_ready = 1'b0;
        end

        if (flow_errors == 0) begin
            goal = retired + 200;
            n    = 0;
            while (retired < goal && n < 20000) begin
                @(negedge clk);
                n++;
            end
            if (retired < goal) begin
                flow_errors++;
                $display("Error: timed out retiring after back-pressure was released");
            end
        end

        // stop fetching and let everything in flight retire
        if (flow_errors == 0) begin
            fetch_en = 1'b0;
            n        = 0;
            do begin
                @(negedge clk);
                n++;
            end while ((fetch_q.size() != 0 || rob_q.size() != 0 || i_fetch_valid) && n < 2000);
            if (fetch_q.size() != 0 || rob_q.size() != 0) begin
                flow_errors++;
                $display("Error: instructions still in flight at the end of the drain");
            end
        end

        $display("retired=%0d issued=%0d squashes=%0d errors=%0d flow_errors=%0d",
            retired, issued, squashes, errors, flow_errors);
        if (errors == 0 && flow_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

// File: hdl/ctrl_block.sv
`timescale 1ns/100ps

module ctrl_block import ctrl_pkg::*; #(
    parameter int IBUF_DEPTH = 4,
    parameter int ROB_DEPTH  = 16
) (
    input  logic         clk,
    input  logic         i_rst,

    // fetch
    input  logic         i_fetch_valid,
    output logic         o_fetch_ready,
    input  fetch_entry_t i_fetch_data,

    // to execution unit
    output logic         o_issue_valid,
    input  logic         i_issue_ready,
    output issue_info_t  o_issue_info,

    // writeback by rob index
    input  logic         i_wb_valid,
    input  wb_info_t     i_wb_info,

    output logic         o_commit_valid,
    output commit_info_t o_commit_info,

    output logic         o_squash_valid,
    output squash_info_t o_squash_info
);
    logic         ibuf_valid;
    logic         ibuf_ready;
    fetch_entry_t ibuf_data;

    logic         dec_valid;
    logic         dec_ready;
    dec_info_t    dec_info;

    logic         ren_valid;
    logic         ren_ready;
    rename_info_t ren_info;

    inst_buffer #(.IBUF_DEPTH(IBUF_DEPTH)) u_inst_buffer (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (o_squash_valid),
        .i_enq_valid (i_fetch_valid),
        .o_enq_ready (o_fetch_ready),
        .i_enq_data  (i_fetch_data),
        .o_deq_valid (ibuf_valid),
        .i_deq_ready (ibuf_ready),
        .o_deq_data  (ibuf_data)
    );

    decode u_decode (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_flush (o_squash_valid),
        .i_valid (ibuf_valid),
        .o_ready (ibuf_ready),
        .i_entry (ibuf_data),
        .o_valid (dec_valid),
        .i_ready (dec_ready),
        .o_info  (dec_info)
    );

    // commit pulse frees old_pdst and updates the committed map
    rename u_rename (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_flush        (o_squash_valid),
        .i_valid        (dec_valid),
        .o_ready        (dec_ready),
        .i_info         (dec_info),
        .o_valid        (ren_valid),
        .i_ready        (ren_ready),
        .o_info         (ren_info),
        .i_commit_valid (o_commit_valid),
        .i_commit_info  (o_commit_info)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (ren_valid),
        .o_ready        (ren_ready),
        .i_info         (ren_info),
        .o_issue_valid  (o_issue_valid),
        .i_issue_ready  (i_issue_ready),
        .o_issue_info   (o_issue_info),
        .i_wb_valid     (i_wb_valid),
        .i_wb_info      (i_wb_info),
        .o_commit_valid (o_commit_valid),
        .o_commit_info  (o_commit_info),
        .o_squash_valid (o_squash_valid),
        .o_squash_info  (o_squash_info)
    );

endmodule

// File: hdl/rob.sv
`timescale 1ns/100ps

module rob import ctrl_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic         clk,
    input  logic         i_rst,

    input  logic         i_valid,
    output logic         o_ready,
    input  rename_info_t i_info,

    output logic         o_issue_valid,
    input  logic         i_issue_ready,
    output issue_info_t  o_issue_info,

    input  logic         i_wb_valid,
    input  wb_info_t     i_wb_info,

    output logic         o_commit_valid,
    output commit_info_t o_commit_info,

    output logic         o_squash_valid,
    output squash_info_t o_squash_info
);
    localparam int IDX_W = $clog2(ROB_DEPTH);

    commit_info_t    entry_q  [ROB_DEPTH];
    logic [XLEN-1:0] target_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] illegal_q;
    logic [ROB_DEPTH-1:0] mispred_q;

    // extra msb tells full from empty
    logic [IDX_W:0]   head_q;
    logic [IDX_W:0]   tail_q;
    logic [IDX_W:0]   count;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] wb_idx;
    logic [IDX_W-1:0] wb_off;
    logic             wb_in_range;
    logic             full;
    logic             empty;
    logic             retire;
    logic             squash;
    logic             alloc;
    logic             new_illegal;

    assign count    = tail_q - head_q;
    assign head_idx = head_q[IDX_W-1:0];
    assign tail_idx = tail_q[IDX_W-1:0];
    assign full     = (count == (IDX_W+1)'(ROB_DEPTH));
    assign empty    = (count == '0);

    assign wb_idx      = i_wb_info.rob_idx[IDX_W-1:0];
    assign wb_off      = wb_idx - head_idx;
    assign wb_in_range = ({1'b0, wb_off} < count);

    assign retire = !empty && done_q[head_idx];
    assign squash = retire && (illegal_q[head_idx] || mispred_q[head_idx]);

    // dispatch and issue share one handshake
    assign o_issue_valid = i_valid && !full && !squash;
    assign o_ready       = i_issue_ready && !full && !squash;
    assign alloc         = o_issue_valid && i_issue_ready;
    assign new_illegal   = (i_info.dec.op == OP_ILLEGAL);

    always_comb begin
        o_issue_info.rob_idx = rob_idx_t'(tail_idx);
        o_issue_info.op      = i_info.dec.op;
        o_issue_info.psrc1   = i_info.psrc1;
        o_issue_info.psrc2   = i_info.psrc2;
        o_issue_info.pdst    = i_info.pdst;
    end

    // illegal head squashes without committing
    assign o_commit_valid      = retire && !illegal_q[head_idx];
    assign o_commit_info       = entry_q[head_idx];
    assign o_squash_valid      = squash;
    assign o_squash_info.cause = illegal_q[head_idx] ? SQ_EXCEPT : SQ_MISPRED;
    assign o_squash_info.pc    = illegal_q[head_idx] ? entry_q[head_idx].pc + 32'd4
                                                     : target_q[head_idx];

    always_ff @(posedge clk) begin
        if (i_rst || squash) begin
            head_q <= '0;
            tail_q <= '0;
            done_q <= '0;
        end else begin
            if (alloc) begin
                tail_q           <= tail_q + 1'b1;
                done_q[tail_idx] <= new_illegal;
            end
            if (i_wb_valid && wb_in_range) begin
                done_q[wb_idx] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_q[tail_idx].rob_idx  <= rob_idx_t'(tail_idx);
            entry_q[tail_idx].pc       <= i_info.dec.pc;
            entry_q[tail_idx].rd       <= i_info.dec.rd;
            entry_q[tail_idx].has_dest <= i_info.dec.has_dest;
            entry_q[tail_idx].pdst     <= i_info.pdst;
            entry_q[tail_idx].old_pdst <= i_info.old_pdst;
            illegal_q[tail_idx]        <= new_illegal;
            mispred_q[tail_idx]        <= 1'b0;
        end
        if (i_wb_valid && wb_in_range) begin
            mispred_q[wb_idx] <= i_wb_info.mispred;
            target_q[wb_idx]  <= i_wb_info.target;
        end
    end

    // the execution unit only answers for live entries, once each
    a_wb_in_window: assert property (@(posedge clk) disable iff (i_rst)
        i_wb_valid |-> wb_in_range);

    a_wb_once: assert property (@(posedge clk) disable iff (i_rst)
        (i_wb_valid && !squash) |-> !done_q[wb_idx]);

endmodule

// File: hdl/rename.sv
`timescale 1ns/100ps

module rename import ctrl_pkg::*; (
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_flush,

    input  logic         i_valid,
    output logic         o_ready,
    input  dec_info_t    i_info,

    output logic         o_valid,
    input  logic         i_ready,
    output rename_info_t o_info,

    input  logic         i_commit_valid,
    input  commit_info_t i_commit_info
);
    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_IDX_W = $clog2(FL_DEPTH);
    localparam int FL_PTR_W = FL_IDX_W + 1;

    preg_t spec_map_q    [ARCH_REGS];
    preg_t commit_map_q  [ARCH_REGS];
    preg_t commit_map_nxt[ARCH_REGS];
    preg_t fl_q          [FL_DEPTH];

    logic [FL_PTR_W-1:0] spec_head_q;
    logic [FL_PTR_W-1:0] commit_head_q;
    logic [FL_PTR_W-1:0] commit_head_nxt;
    logic [FL_PTR_W-1:0] tail_q;
    logic [FL_PTR_W-1:0] fl_count;
    logic                fl_empty;

    logic         valid_q;
    rename_info_t info_q;
    rename_info_t ren_next;
    logic         fire;
    logic         pop;
    logic         commit_free;

    assign fl_count    = tail_q - spec_head_q;
    assign fl_empty    = (fl_count == '0);
    assign commit_free = i_commit_valid && i_commit_info.has_dest;

    // stall when a destination is needed but nothing is free
    assign o_ready = (!valid_q || i_ready) && !(i_info.has_dest && fl_empty);
    assign fire    = i_valid && o_ready;
    assign pop     = fire && i_info.has_dest && !i_flush;
    assign o_valid = valid_q;
    assign o_info  = info_q;

    always_comb begin
        ren_next.dec      = i_info;
        ren_next.psrc1    = spec_map_q[i_info.rs1];
        ren_next.psrc2    = spec_map_q[i_info.rs2];
        ren_next.pdst     = i_info.has_dest ? fl_q[spec_head_q[FL_IDX_W-1:0]] : '0;
        ren_next.old_pdst = i_info.has_dest ? spec_map_q[i_info.rd] : '0;
    end

    // committed state including this cycle's commit, also the squash restore point
    always_comb begin
        commit_map_nxt  = commit_map_q;
        commit_head_nxt = commit_head_q;
        if (commit_free) begin
            commit_map_nxt[i_commit_info.rd] = i_commit_info.pdst;
            commit_head_nxt                  = commit_head_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q       <= 1'b0;
            spec_head_q   <= '0;
            commit_head_q <= '0;
            tail_q        <= FL_PTR_W'(FL_DEPTH);
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map_q[i]   <= preg_t'(i);
                commit_map_q[i] <= preg_t'(i);
            end
            // upper half of the register file starts free
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_q[i] <= preg_t'(ARCH_REGS + i);
            end
        end else begin
            commit_map_q  <= commit_map_nxt;
            commit_head_q <= commit_head_nxt;
            if (commit_free) begin
                fl_q[tail_q[FL_IDX_W-1:0]] <= i_commit_info.old_pdst;
                tail_q                     <= tail_q + 1'b1;
            end
            if (i_flush) begin
                valid_q     <= 1'b0;
                spec_map_q  <= commit_map_nxt;
                spec_head_q <= commit_head_nxt;
            end else begin
                if (fire) begin
                    valid_q <= 1'b1;
                end else if (i_ready) begin
                    valid_q <= 1'b0;
                end
                if (pop) begin
                    spec_map_q[i_info.rd] <= ren_next.pdst;
                    spec_head_q           <= spec_head_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !i_flush) begin
            info_q <= ren_next;
        end
    end

    // the speculative head never runs past the tail refilled by commits
    a_fl_no_underflow: assert property (@(posedge clk) disable iff (i_rst)
        pop |=> (fl_count <= FL_PTR_W'(FL_DEPTH)));

endmodule

// File: hdl/decode.sv
`timescale 1ns/100ps

module decode import ctrl_pkg::*; (
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_flush,

    input  logic         i_valid,
    output logic         o_ready,
    input  fetch_entry_t i_entry,

    output logic         o_valid,
    input  logic         i_ready,
    output dec_info_t    o_info
);
    logic      valid_q;
    dec_info_t info_q;
    dec_info_t dec_next;
    logic      fire;

    // major opcode lookup
    always_comb begin
        dec_next.pc  = i_entry.pc;
        dec_next.rs1 = i_entry.inst[19:15];
        dec_next.rs2 = i_entry.inst[24:20];
        dec_next.rd  = i_entry.inst[11:7];
        case (i_entry.inst[6:0])
            7'h13, 7'h33: dec_next.op = OP_ALU;
            7'h03:        dec_next.op = OP_LOAD;
            7'h23:        dec_next.op = OP_STORE;
            7'h63:        dec_next.op = OP_BRANCH;
            default:      dec_next.op = OP_ILLEGAL;
        endcase
        // only alu and load results land in a register, x0 excluded
        dec_next.has_dest = ((dec_next.op == OP_ALU) || (dec_next.op == OP_LOAD))
                            && (dec_next.rd != '0);
    end

    assign o_ready = !valid_q || i_ready;
    assign fire    = i_valid && o_ready;
    assign o_valid = valid_q;
    assign o_info  = info_q;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            valid_q <= 1'b0;
        end else if (fire) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;
        end
    end

    // held while downstream stalls
    always_ff @(posedge clk) begin
        if (fire) begin
            info_q <= dec_next;
        end
    end

endmodule

// File: hdl/inst_buffer.sv
`timescale 1ns/100ps

module inst_buffer import ctrl_pkg::*; #(
    parameter int IBUF_DEPTH = 4
) (
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_flush,

    input  logic         i_enq_valid,
    output logic         o_enq_ready,
    input  fetch_entry_t i_enq_data,

    output logic         o_deq_valid,
    input  logic         i_deq_ready,
    output fetch_entry_t o_deq_data
);
    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

    fetch_entry_t     mem_q [IBUF_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             enq_fire;
    logic             deq_fire;

    // nothing enters while a squash is in flight
    assign o_enq_ready = (count_q != CNT_W'(IBUF_DEPTH)) && !i_flush;
    assign o_deq_valid = (count_q != '0);
    assign o_deq_data  = mem_q[rd_ptr_q];

    assign enq_fire = i_enq_valid && o_enq_ready;
    assign deq_fire = o_deq_valid && i_deq_ready;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(IBUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(IBUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(enq_fire) - CNT_W'(deq_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem_q[wr_ptr_q] <= i_enq_data;
        end
    end

    // write pointer sits exactly count entries past the read pointer
    a_no_enq_full: assert property (@(posedge clk) disable iff (i_rst)
        (count_q <= CNT_W'(IBUF_DEPTH))
        && (wr_ptr_q == PTR_W'((rd_ptr_q + count_q) % IBUF_DEPTH)));

endmodule

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

    // register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    localparam int XLEN      = 32;
    localparam int AREG_W    = $clog2(ARCH_REGS);
    localparam int PREG_W    = $clog2(PHYS_REGS);
    localparam int ROB_IDX_W = 4;

    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic {
        SQ_EXCEPT,
        SQ_MISPRED
    } squash_cause_e;

    // fetch interface payload
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_class_e       op;
        areg_t           rs1;
        areg_t           rs2;
        areg_t           rd;
        logic            has_dest;
    } dec_info_t;

    typedef struct packed {
        dec_info_t dec;
        preg_t     psrc1;
        preg_t     psrc2;
        preg_t     pdst;
        preg_t     old_pdst;
    } rename_info_t;

    // sent to the execution unit
    typedef struct packed {
        rob_idx_t  rob_idx;
        op_class_e op;
        preg_t     psrc1;
        preg_t     psrc2;
        preg_t     pdst;
    } issue_info_t;

    typedef struct packed {
        rob_idx_t        rob_idx;
        logic            mispred;
        logic [XLEN-1:0] target;
    } wb_info_t;

    typedef struct packed {
        rob_idx_t        rob_idx;
        logic [XLEN-1:0] pc;
        areg_t           rd;
        logic            has_dest;
        preg_t           pdst;
        preg_t           old_pdst;
    } commit_info_t;

    typedef struct packed {
        squash_cause_e   cause;
        logic [XLEN-1:0] pc;
    } squash_info_t;

endpackage
